//--- common/catch_consts.svh
`ifndef CATCH_CONSTS_SVH
`define CATCH_CONSTS_SVH

// Number of LEDs on the board, and of the switches that must match them.
`define CATCH_LED_COUNT 16

// Levels in one game. Clearing the last one gives the final score.
`define CATCH_LEVEL_COUNT 50

// Wide enough for level indices 0 to 50.
`define CATCH_LEVEL_WIDTH 6

// Score is shown as decimal tens and ones.
`define CATCH_BCD_DIGITS 2

`endif

//--- common/catch_pkg.sv
`default_nettype none

`include "catch_consts.svh"

package catch_pkg;

    // One LED word, or one switch word.
    typedef logic [`CATCH_LED_COUNT-1:0] led_t;

    typedef logic [`CATCH_LEVEL_WIDTH-1:0] level_t;

    typedef logic [3:0] bcd_digit_t;

    // Tens sit in the upper nibble so the word reads as the score in hex.
    typedef struct packed {
        bcd_digit_t tens;
        bcd_digit_t ones;
    } score_bcd_t;

endpackage

`default_nettype wire

//--- game/led_pattern_rom.sv
`timescale 1ns/1ps
`default_nettype none

module led_pattern_rom (
    input  catch_pkg::level_t level,
    output catch_pkg::led_t   pattern
);

    // Each pattern differs from the one before it in a single LED.
    always_comb
    begin
        case (level)
            0:  pattern = 16'b0000_0000_0000_0100;
            1:  pattern = 16'b0000_0000_0010_0100;
            2:  pattern = 16'b0000_0001_0010_0100;
            3:  pattern = 16'b0000_1001_0010_0100;
            4:  pattern = 16'b0000_1001_0010_0110;
            5:  pattern = 16'b0000_1001_0010_1110;
            6:  pattern = 16'b0000_1001_1010_1110;
            7:  pattern = 16'b0000_1011_1010_1110;
            8:  pattern = 16'b0000_1011_1000_1110;
            9:  pattern = 16'b0000_0011_1000_1110;
            10: pattern = 16'b0000_0011_1000_1100;
            11: pattern = 16'b0000_0011_1000_1101;
            12: pattern = 16'b0000_0011_1001_1101;
            13: pattern = 16'b0010_0011_1001_1101;
            14: pattern = 16'b0010_0011_1101_1101;
            15: pattern = 16'b0010_0010_1101_1101;
            16: pattern = 16'b0010_0110_1101_1101;
            17: pattern = 16'b0011_0110_1101_1101;
            18: pattern = 16'b0011_0110_1101_0101;
            19: pattern = 16'b1011_0110_1101_0101;
            20: pattern = 16'b1011_0110_0101_0101;
            21: pattern = 16'b1111_0110_0101_0101;
            22: pattern = 16'b1111_0110_1101_0101;
            23: pattern = 16'b1111_0110_1100_0101;
            24: pattern = 16'b1011_0110_1100_0101;
            25: pattern = 16'b1011_0110_1110_0101;
            26: pattern = 16'b1011_0110_1110_0111;
            27: pattern = 16'b1011_0110_1110_0110;
            28: pattern = 16'b1011_0010_1110_0110;
            29: pattern = 16'b1011_0000_1110_0110;
            30: pattern = 16'b1011_0000_1110_1110;
            31: pattern = 16'b1011_0000_1110_1100;
            32: pattern = 16'b0011_0000_1110_1100;
            33: pattern = 16'b0111_0000_1110_1100;
            34: pattern = 16'b0111_0001_1110_1100;
            35: pattern = 16'b0111_0001_1110_1000;
            36: pattern = 16'b0111_0001_1010_1000;
            37: pattern = 16'b0111_0001_1010_1001;
            38: pattern = 16'b1111_0001_1010_1001;
            39: pattern = 16'b1111_0001_1010_1011;
            40: pattern = 16'b1011_0001_1010_1011;
            41: pattern = 16'b1011_0001_1010_1111;
            42: pattern = 16'b1011_0001_1110_1111;
            43: pattern = 16'b1011_0001_1100_1111;
            44: pattern = 16'b1011_0001_1100_0111;
            45: pattern = 16'b1011_0001_0100_0111;
            46: pattern = 16'b1011_0011_0100_0111;
            47: pattern = 16'b1011_1011_0100_0111;
            48: pattern = 16'b1001_1011_0100_0111;
            49: pattern = 16'b1001_1011_0000_0111;
            default: pattern = '0; // Level 50 and above has no pattern because the game is over.
        endcase
    end

endmodule

`default_nettype wire

//--- game/level_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "catch_consts.svh"

module level_sequencer (
    input  logic              clk,
    input  logic              rst,
    input  catch_pkg::led_t   switches,
    input  logic              time_up,
    input  catch_pkg::led_t   pattern,
    output catch_pkg::level_t level,
    output logic              advance,
    output logic              play_active
);

    import catch_pkg::*;

    localparam level_t FINAL_LEVEL = level_t'(`CATCH_LEVEL_COUNT);

    logic at_final;
    logic match;

    assign at_final    = (level == FINAL_LEVEL);
    assign play_active = !time_up && !at_final;

    // Switches are compared with the table, not with the registered LEDs.
    assign match = play_active && (switches == pattern);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            level   <= '0;
            advance <= 1'b0;
        end
        else
        begin
            advance <= match; // One pulse per cleared level.
            if (match)
            begin
                level <= level + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- score/bcd_digit.sv
`timescale 1ns/1ps
`default_nettype none

module bcd_digit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inc,
    output catch_pkg::bcd_digit_t digit,
    output logic                  carry
);

    import catch_pkg::*;

    localparam bcd_digit_t DIGIT_MAX = 4'd9;

    // Carry tells the next digit up to count in the same cycle this one wraps.
    assign carry = inc && (digit == DIGIT_MAX);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            digit <= '0;
        end
        else if (inc)
        begin
            digit <= (digit == DIGIT_MAX) ? '0 : digit + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- score/score_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "catch_consts.svh"

module score_counter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  advance,
    output catch_pkg::score_bcd_t score
);

    import catch_pkg::*;

    bcd_digit_t [`CATCH_BCD_DIGITS-1:0] digits;
    logic       [`CATCH_BCD_DIGITS:0]   chain;

    assign chain[0] = advance;

    generate
        for (genvar i = 0; i < `CATCH_BCD_DIGITS; i++)
        begin : g_digit
            bcd_digit u_digit (
                .clk   (clk),
                .rst   (rst),
                .inc   (chain[i]),
                .digit (digits[i]),
                .carry (chain[i+1])
            );
        end
    endgenerate

    // The score stops at 50, so the carry out of the top digit never fires.
    assign score = score_bcd_t'(digits); // Highest digit lands in the tens field.

endmodule

`default_nettype wire

//--- source/led_driver.sv
`timescale 1ns/1ps
`default_nettype none

module led_driver (
    input  logic            clk,
    input  logic            rst,
    input  logic            play_active,
    input  logic            blink,
    input  catch_pkg::led_t pattern,
    output catch_pkg::led_t led
);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            led <= '0;
        end
        else if (play_active)
        begin
            led <= pattern;
        end
        else
        begin
            // Once play stops the whole row flashes. It is dark while blink is high.
            led <= blink ? '0 : '1;
        end
    end

endmodule

`default_nettype wire

//--- source/catch_the_light.sv
`timescale 1ns/1ps
`default_nettype none

module catch_the_light (
    input  logic                  clk,
    input  logic                  rst,
    input  catch_pkg::led_t       switches,
    input  logic                  time_up,
    input  logic                  blink,
    output catch_pkg::led_t       led,
    output catch_pkg::score_bcd_t score
);

    import catch_pkg::*;

    level_t level;
    led_t   pattern;
    logic   advance;
    logic   play_active;

    led_pattern_rom u_rom (
        .level   (level),
        .pattern (pattern)
    );

    level_sequencer u_sequencer (
        .clk         (clk),
        .rst         (rst),
        .switches    (switches),
        .time_up     (time_up),
        .pattern     (pattern),
        .level       (level),
        .advance     (advance),
        .play_active (play_active)
    );

    // Score trails the level by one cycle.
    score_counter u_score (
        .clk     (clk),
        .rst     (rst),
        .advance (advance),
        .score   (score)
    );

    led_driver u_led (
        .clk         (clk),
        .rst         (rst),
        .play_active (play_active),
        .blink       (blink),
        .pattern     (pattern),
        .led         (led)
    );

endmodule

`default_nettype wire

//--- testbench/catch_the_light_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "catch_consts.svh"

module catch_the_light_asserts (
    input logic                  clk,
    input logic                  rst,
    input catch_pkg::led_t       switches,
    input logic                  time_up,
    input logic                  blink,
    input catch_pkg::led_t       led,
    input catch_pkg::score_bcd_t score
);

    import catch_pkg::*;

    localparam score_bcd_t FINAL_SCORE = '{tens: 4'(`CATCH_LEVEL_COUNT / 10),
                                           ones: 4'(`CATCH_LEVEL_COUNT % 10)};
    localparam led_t FIRST_PATTERN = 16'h0004; // Level 0 lights LED 2 only.

    int fail_count = 0;

    logic       play;
    logic       hit;
    logic       quiet;
    logic       rst_d1;
    logic       rst_d2;
    logic       hit_d1;
    logic       hit_d2;
    logic       quiet_d1;
    logic       quiet_d2;
    logic       time_up_d1;
    logic       time_up_d2;
    logic       blink_d1;
    score_bcd_t score_d1;
    led_t       led_d1;
    led_t       led_d2;

    assign play  = !time_up && (score != FINAL_SCORE);
    assign hit   = !rst && play && (switches == led); // Player caught the light.
    assign quiet = !rst && !time_up && (switches != led);

    always @(posedge clk)
    begin
        rst_d1     <= rst;
        rst_d2     <= rst_d1;
        hit_d1     <= hit;
        hit_d2     <= hit_d1;
        quiet_d1   <= quiet;
        quiet_d2   <= quiet_d1;
        time_up_d1 <= !rst && time_up;
        time_up_d2 <= time_up_d1;
        blink_d1   <= blink;
        score_d1   <= score;
        led_d1     <= led;
        led_d2     <= led_d1;
    end

    function automatic score_bcd_t bcd_next(input score_bcd_t s);
        score_bcd_t n;
        n = s;
        if (s.ones == 4'd9)
        begin
            n.ones = 4'd0;
            n.tens = s.tens + 4'd1;
        end
        else
        begin
            n.ones = s.ones + 4'd1;
        end
        return n;
    endfunction

    // Dark while blink is high, fully lit while it is low.
    function automatic led_t blink_word(input logic b);
        return {`CATCH_LED_COUNT{!b}};
    endfunction

    task automatic count_failure(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual);
        fail_count++;
        $error("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    a_reset_led: assert property (@(posedge clk) disable iff (rst) rst_d1 |-> led == '0)
        else count_failure("led", '0, $sampled(led));
    a_reset_score: assert property (@(posedge clk) disable iff (rst) rst_d1 |-> score == '0)
        else count_failure("score", '0, $sampled(score));
    a_first_pattern: assert property (@(posedge clk) disable iff (rst)
        (rst_d2 && !rst_d1) |-> led == FIRST_PATTERN)
        else count_failure("led", FIRST_PATTERN, $sampled(led));
    a_score_hold: assert property (@(posedge clk) disable iff (rst)
        (quiet_d2 || time_up_d2) |-> score == score_d1)
        else count_failure("score", $sampled(score_d1), $sampled(score));
    a_score_step: assert property (@(posedge clk) disable iff (rst)
        hit_d2 |-> score == bcd_next(score_d1))
        else count_failure("score", bcd_next($sampled(score_d1)), $sampled(score));
    a_led_step: assert property (@(posedge clk) disable iff (rst)
        (hit_d2 && score != FINAL_SCORE) |-> $onehot(led ^ led_d2))
        else count_failure("led", $sampled(led_d2), $sampled(led));
    a_ones_range: assert property (@(posedge clk) disable iff (rst) score.ones <= 4'd9)
        else count_failure("score.ones", 16'd9, $sampled(score.ones));
    a_tens_carry: assert property (@(posedge clk) disable iff (rst)
        (score.tens != score_d1.tens) |-> (score_d1.ones == 4'd9) && (score.ones == 4'd0)
            && (score.tens == score_d1.tens + 4'd1))
        else count_failure("score", bcd_next($sampled(score_d1)), $sampled(score));
    a_final_hold: assert property (@(posedge clk) disable iff (rst)
        (score_d1 == FINAL_SCORE) |-> score == FINAL_SCORE)
        else count_failure("score", FINAL_SCORE, $sampled(score));
    a_blink_rule: assert property (@(posedge clk) disable iff (rst)
        (time_up_d1 || score_d1 == FINAL_SCORE) |-> led == blink_word(blink_d1))
        else count_failure("led", blink_word($sampled(blink_d1)), $sampled(led));

endmodule

bind catch_the_light catch_the_light_asserts u_asserts (
    .clk      (clk),
    .rst      (rst),
    .switches (switches),
    .time_up  (time_up),
    .blink    (blink),
    .led      (led),
    .score    (score)
);

`default_nettype wire

//--- testbench/tb_catch_the_light.sv
`timescale 1ns/1ps
`default_nettype none

`include "catch_consts.svh"

module tb_catch_the_light;

    import catch_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int DRIVE_DELAY     = 1;
    localparam int GAME_TWO_LEVELS = 10;

    // Two cycles per level, plus reset, misses and the blink phase.
    localparam int GAME_ONE_CYCLES = 2 + 4 + 2 * `CATCH_LEVEL_COUNT + 12;
    localparam int GAME_TWO_CYCLES = 2 + 3 + 2 * GAME_TWO_LEVELS + 10;
    localparam int WATCHDOG_CYCLES = 2 * (GAME_ONE_CYCLES + GAME_TWO_CYCLES);

    logic       clk;
    logic       rst;
    led_t       switches;
    logic       time_up;
    logic       blink;
    led_t       led;
    score_bcd_t score;
    integer     seed;

    catch_the_light u_dut (
        .clk      (clk),
        .rst      (rst),
        .switches (switches),
        .time_up  (time_up),
        .blink    (blink),
        .led      (led),
        .score    (score)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (2) next_cycle();
        rst = 1'b0;
    endtask

    // Random switch word that differs from the LEDs on show.
    task automatic drive_miss();
        led_t word;
        word = led_t'($random(seed));
        while (word == led)
        begin
            word = led_t'($random(seed));
        end
        switches = word;
        next_cycle();
    endtask

    task automatic catch_level();
        switches = led;
        next_cycle();
        drive_miss(); // The new pattern only shows one cycle later.
    endtask

    initial
    begin
        seed     = 32'hb9bdce7f;
        rst      = 1'b1;
        switches = '1;
        time_up  = 1'b0;
        blink    = 1'b0;

        apply_reset();
        repeat (4) drive_miss();
        repeat (`CATCH_LEVEL_COUNT) catch_level();
        repeat (6)
        begin
            blink = ~blink;
            repeat (2) next_cycle();
        end

        // Second game is cut short by the timer.
        apply_reset();
        repeat (3) drive_miss();
        repeat (GAME_TWO_LEVELS) catch_level();
        time_up = 1'b1;
        repeat (8)
        begin
            switches = led;
            blink    = ~blink;
            next_cycle();
        end
        repeat (2) next_cycle();

        if (u_dut.u_asserts.fail_count == 0)
        begin
            $display("*** PASSED ***");
            $finish;
        end
        else
        begin
            $display("*** FAILED ***");
            $fatal(1, "Assertion failures were counted.");
        end
    end

    initial
    begin
        wait (u_dut.u_asserts.fail_count != 0);
        $display("*** FAILED ***");
        $fatal(1, "A game rule assertion failed.");
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles.", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $fatal(1, "Watchdog expired.");
    end

endmodule

`default_nettype wire

//--- Bender.yml
package:
  name: catch_the_light

export_include_dirs:
  - common

sources:
  - files:
      - common/catch_pkg.sv
      - game/led_pattern_rom.sv
      - game/level_sequencer.sv
      - score/bcd_digit.sv
      - score/score_counter.sv
      - source/led_driver.sv
      - source/catch_the_light.sv
  - target: test
    files:
      - testbench/catch_the_light_asserts.sv
      - testbench/tb_catch_the_light.sv

//--- catch_the_light.f
+incdir+common
common/catch_pkg.sv
game/led_pattern_rom.sv
game/level_sequencer.sv
score/bcd_digit.sv
score/score_counter.sv
source/led_driver.sv
source/catch_the_light.sv
testbench/catch_the_light_asserts.sv
testbench/tb_catch_the_light.sv
